// File: rtl/disk_geometry_pkg.sv
// Storage data widths and types

package disk_geometry_pkg;

	// ============================================================
	// Sizes
	// ============================================================
	localparam int SECTOR_BYTES = 512;
	localparam int NUM_DRIVES   = 8;

	// ============================================================
	// Data types
	// ============================================================
	// One byte of sector data
	typedef logic [7:0]  byte_t;

	// Block address, also reused for the image size
	typedef logic [31:0] lba_t;

	// Word as seen on the controller data path
	typedef logic [31:0] ctl_word_t;

	// Byte offset inside one sector
	typedef logic [8:0]  buf_addr_t;

	// Drive slot index and per-slot bit vector
	typedef logic [2:0]  drive_t;
	typedef logic [7:0]  drive_mask_t;

	// Image file type code
	typedef logic [1:0]  file_type_t;

endpackage

// File: rtl/bridge_ctrl_pkg.sv
// Controller protocol definitions

package bridge_ctrl_pkg;

	// ============================================================
	// Block request handshake
	// ============================================================
	// IDLE waits for a start edge, REQUEST holds the request bit
	// until ack, WAIT_RELEASE waits for every ack bit to drop
	typedef enum logic [1:0] {
		IDLE         = 2'd0,
		REQUEST      = 2'd1,
		WAIT_RELEASE = 2'd2
	} block_state_t;

	// ============================================================
	// Slot policy
	// ============================================================
	// Slots 4 and 5 always report read-only
	localparam disk_geometry_pkg::drive_mask_t READONLY_SLOTS = 8'b0011_0000;

endpackage

// File: rtl/sector_bus_if.sv
// Controller sector buffer port
`timescale 1ns/1ps

interface sector_bus_if;

	disk_geometry_pkg::buf_addr_t addr;
	disk_geometry_pkg::byte_t     wdata;
	logic                         we;
	disk_geometry_pkg::byte_t     rdata;

	// Address counter side
	modport ctl (
		output addr,
		output wdata,
		output we
	);

	// RAM side
	modport mem (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

	// Observer for the top level
	modport mon (
		input  rdata,
		input  addr
	);

endinterface

// File: rtl/sector_buffer.sv
// Dual-port sector RAM
`timescale 1ns/1ps

module sector_buffer (
	input  logic                         clk_sys,
	sector_bus_if.mem                    bus,
	input  disk_geometry_pkg::buf_addr_t host_addr_i,
	input  disk_geometry_pkg::byte_t     host_wdata_i,
	input  logic                         host_we_i,
	output disk_geometry_pkg::byte_t     host_rdata_o
);

	disk_geometry_pkg::byte_t mem [disk_geometry_pkg::SECTOR_BYTES];

	disk_geometry_pkg::byte_t ctl_q;
	disk_geometry_pkg::byte_t host_q;

	// ============================================================
	// Both ports, write then registered read
	// ============================================================
	// Reads return the old contents on a same-cycle write
	always_ff @(posedge clk_sys) begin
		if (bus.we) begin
			mem[bus.addr] <= bus.wdata;
		end
		if (host_we_i) begin
			mem[host_addr_i] <= host_wdata_i;
		end
		ctl_q  <= mem[bus.addr];
		host_q <= mem[host_addr_i];
	end

	assign bus.rdata    = ctl_q;
	assign host_rdata_o = host_q;

	// Controller and host must never write the same byte together
	a_no_write_clash: assert property (
		@(posedge clk_sys) !(bus.we && host_we_i && (bus.addr == host_addr_i))
	) else $error("sector_buffer: both ports write address %h", bus.addr);

endmodule

// File: rtl/buffer_addr_counter.sv
// Controller buffer address counter
`timescale 1ns/1ps

module buffer_addr_counter (
	input  logic                     clk_sys,
	input  logic                     areset,
	input  logic                     lba_sel_i,
	input  logic                     data_wr_i,
	input  logic                     data_rd_i,
	input  logic                     io_wr_i,
	input  disk_geometry_pkg::byte_t wdata_i,
	sector_bus_if.ctl                bus,
	output logic                     lba_load_o
);

	logic wr_s1;
	logic wr_s2;
	logic rd_q;
	logic wr_rise;
	logic rd_fall;
	logic buf_we;

	disk_geometry_pkg::buf_addr_t addr_q;

	// ============================================================
	// Strobe edges
	// ============================================================
	// Write strobe goes through two stages, read strobe one
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_s1 <= 1'b0;
			wr_s2 <= 1'b0;
			rd_q  <= 1'b0;
		end else begin
			wr_s1 <= data_wr_i;
			wr_s2 <= wr_s1;
			rd_q  <= data_rd_i;
		end
	end

	assign wr_rise = wr_s1 & ~wr_s2;
	assign rd_fall = rd_q & ~data_rd_i;

	// Steer the byte to the LBA register or the buffer
	assign lba_load_o = wr_rise & lba_sel_i;

	// ============================================================
	// Write enable and address
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			buf_we <= 1'b0;
			addr_q <= '0;
		end else begin
			buf_we <= wr_rise & ~lba_sel_i;
			if (buf_we || rd_fall) begin
				addr_q <= addr_q + 1'b1;
			end
			// Clear wins over a step in the same cycle
			if (io_wr_i) begin
				addr_q <= '0;
			end
		end
	end

	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_i;
	assign bus.we    = buf_we;

	// A write step and a read step landing together would lose one step
	a_no_step_clash: assert property (
		@(posedge clk_sys) disable iff (areset) !(buf_we && rd_fall)
	) else $error("buffer_addr_counter: buffer write and read step together");

endmodule

// File: rtl/block_request_fsm.sv
// Block request handshake and LBA register
`timescale 1ns/1ps

module block_request_fsm (
	input  logic                           clk_sys,
	input  logic                           areset,
	input  logic                           block_rd_i,
	input  logic                           block_wr_i,
	input  disk_geometry_pkg::drive_t      drive_i,
	input  logic                           lba_load_i,
	input  disk_geometry_pkg::lba_t        lba_i,
	input  disk_geometry_pkg::drive_mask_t ack_i,
	output disk_geometry_pkg::drive_mask_t rd_req_o,
	output disk_geometry_pkg::drive_mask_t wr_req_o,
	output disk_geometry_pkg::lba_t        lba_o,
	output logic                           io_done_o
);

	bridge_ctrl_pkg::block_state_t state;

	logic blk_rd_q;
	logic blk_wr_q;
	logic rd_start;
	logic wr_start;
	logic any_ack;

	disk_geometry_pkg::drive_mask_t drive_sel;
	disk_geometry_pkg::drive_mask_t rd_req_q;
	disk_geometry_pkg::drive_mask_t wr_req_q;
	disk_geometry_pkg::lba_t        lba_q;

	// ============================================================
	// Start edges and slot decode
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			blk_rd_q <= 1'b0;
			blk_wr_q <= 1'b0;
		end else begin
			blk_rd_q <= block_rd_i;
			blk_wr_q <= block_wr_i;
		end
	end

	assign rd_start  = block_rd_i & ~blk_rd_q;
	assign wr_start  = block_wr_i & ~blk_wr_q;
	assign any_ack   = |ack_i;
	assign drive_sel = disk_geometry_pkg::drive_mask_t'(1) << drive_i;

	// Loaded by a data strobe with the LBA select high
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			lba_q <= '0;
		end else if (lba_load_i) begin
			lba_q <= lba_i;
		end
	end

	// ============================================================
	// Four-phase request toward the host
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			state     <= bridge_ctrl_pkg::IDLE;
			rd_req_q  <= '0;
			wr_req_q  <= '0;
			io_done_o <= 1'b1;
		end else begin
			unique case (state)
				bridge_ctrl_pkg::IDLE: begin
					// Read wins if both edges land together
					if (rd_start) begin
						rd_req_q  <= drive_sel;
						io_done_o <= 1'b0;
						state     <= bridge_ctrl_pkg::REQUEST;
					end else if (wr_start) begin
						wr_req_q  <= drive_sel;
						io_done_o <= 1'b0;
						state     <= bridge_ctrl_pkg::REQUEST;
					end
				end
				bridge_ctrl_pkg::REQUEST: begin
					// Held as long as the host stays silent
					if (any_ack) begin
						rd_req_q <= '0;
						wr_req_q <= '0;
						state    <= bridge_ctrl_pkg::WAIT_RELEASE;
					end
				end
				bridge_ctrl_pkg::WAIT_RELEASE: begin
					if (!any_ack) begin
						io_done_o <= 1'b1;
						state     <= bridge_ctrl_pkg::IDLE;
					end
				end
				default: begin
					state <= bridge_ctrl_pkg::IDLE;
				end
			endcase
		end
	end

	assign rd_req_o = rd_req_q;
	assign wr_req_o = wr_req_q;
	assign lba_o    = lba_q;

	// Only one slot is ever asked for at a time
	a_single_req: assert property (
		@(posedge clk_sys) disable iff (areset) $onehot0(rd_req_o | wr_req_o)
	) else $error("block_request_fsm: more than one request bit set");

	// Done and an open request exclude each other
	a_done_no_req: assert property (
		@(posedge clk_sys) disable iff (areset) io_done_o |-> ((rd_req_o | wr_req_o) == '0)
	) else $error("block_request_fsm: request open while io_done is high");

endmodule

// File: rtl/mount_tracker.sv
// Image mount event capture
`timescale 1ns/1ps

module mount_tracker (
	input  logic                           clk_sys,
	input  logic                           areset,
	input  disk_geometry_pkg::drive_mask_t img_mounted_i,
	input  logic                           img_readonly_i,
	input  disk_geometry_pkg::lba_t        img_size_i,
	input  disk_geometry_pkg::file_type_t  img_type_i,
	output disk_geometry_pkg::drive_t      fileno_o,
	output disk_geometry_pkg::file_type_t  filetype_o,
	output logic                           readonly_o,
	output logic                           mounted_o,
	output disk_geometry_pkg::lba_t        filesize_o
);

	logic any_mount;
	logic mount_q;
	logic mount_rise;

	disk_geometry_pkg::drive_t hi_slot;

	assign any_mount  = |img_mounted_i;
	assign mount_rise = any_mount & ~mount_q;

	// Highest set bit selects the slot
	always_comb begin
		hi_slot = '0;
		for (int i = 0; i < disk_geometry_pkg::NUM_DRIVES; i++) begin
			if (img_mounted_i[i]) begin
				hi_slot = disk_geometry_pkg::drive_t'(i);
			end
		end
	end

	// ============================================================
	// Event edge and mounted toggle
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mount_q   <= 1'b0;
			mounted_o <= 1'b0;
		end else begin
			mount_q <= any_mount;
			if (mount_rise) begin
				mounted_o <= ~mounted_o;
			end
		end
	end

	// Image details, only meaningful once mounted_o has toggled
	always_ff @(posedge clk_sys) begin
		if (mount_rise) begin
			fileno_o   <= hi_slot;
			filetype_o <= img_type_i;
			readonly_o <= img_readonly_i | bridge_ctrl_pkg::READONLY_SLOTS[hi_slot];
			filesize_o <= img_size_i;
		end
	end

endmodule

// File: rtl/disk_bridge_top.sv
// Disk sector bridge top level
`timescale 1ns/1ps

module disk_bridge_top (
	input  logic                           clk_sys,
	input  logic                           areset,

	// Controller side
	input  logic                           ctl_lba_sel_i,
	input  logic                           ctl_data_wr_i,
	input  logic                           ctl_data_rd_i,
	input  logic                           ctl_io_wr_i,
	input  logic                           ctl_block_rd_i,
	input  logic                           ctl_block_wr_i,
	input  disk_geometry_pkg::drive_t      ctl_drive_i,
	input  disk_geometry_pkg::ctl_word_t   ctl_wdata_i,
	output disk_geometry_pkg::ctl_word_t   ctl_rdata_o,
	output logic                           ctl_io_done_o,
	output logic                           ctl_mounted_o,
	output disk_geometry_pkg::drive_t      ctl_fileno_o,
	output disk_geometry_pkg::file_type_t  ctl_filetype_o,
	output logic                           ctl_readonly_o,

	// Host side
	output disk_geometry_pkg::lba_t        host_lba_o,
	output disk_geometry_pkg::drive_mask_t host_rd_req_o,
	output disk_geometry_pkg::drive_mask_t host_wr_req_o,
	output disk_geometry_pkg::byte_t       host_buf_rdata_o,
	input  disk_geometry_pkg::drive_mask_t host_ack_i,
	input  disk_geometry_pkg::buf_addr_t   host_buf_addr_i,
	input  disk_geometry_pkg::byte_t       host_buf_wdata_i,
	input  logic                           host_buf_we_i,
	input  disk_geometry_pkg::drive_mask_t img_mounted_i,
	input  logic                           img_readonly_i,
	input  disk_geometry_pkg::lba_t        img_size_i,
	input  disk_geometry_pkg::file_type_t  img_type_i
);

	sector_bus_if bus ();

	logic                    lba_load;
	disk_geometry_pkg::lba_t filesize;

	// ============================================================
	// Controller buffer path
	// ============================================================
	buffer_addr_counter u_addr_cnt (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.lba_sel_i  (ctl_lba_sel_i),
		.data_wr_i  (ctl_data_wr_i),
		.data_rd_i  (ctl_data_rd_i),
		.io_wr_i    (ctl_io_wr_i),
		.wdata_i    (ctl_wdata_i[7:0]),
		.bus        (bus.ctl),
		.lba_load_o (lba_load)
	);

	sector_buffer u_buffer (
		.clk_sys      (clk_sys),
		.bus          (bus.mem),
		.host_addr_i  (host_buf_addr_i),
		.host_wdata_i (host_buf_wdata_i),
		.host_we_i    (host_buf_we_i),
		.host_rdata_o (host_buf_rdata_o)
	);

	// ============================================================
	// Host requests and mount events
	// ============================================================
	block_request_fsm u_req_fsm (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.block_rd_i (ctl_block_rd_i),
		.block_wr_i (ctl_block_wr_i),
		.drive_i    (ctl_drive_i),
		.lba_load_i (lba_load),
		.lba_i      (disk_geometry_pkg::lba_t'(ctl_wdata_i)),
		.ack_i      (host_ack_i),
		.rd_req_o   (host_rd_req_o),
		.wr_req_o   (host_wr_req_o),
		.lba_o      (host_lba_o),
		.io_done_o  (ctl_io_done_o)
	);

	mount_tracker u_mount (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.fileno_o       (ctl_fileno_o),
		.filetype_o     (ctl_filetype_o),
		.readonly_o     (ctl_readonly_o),
		.mounted_o      (ctl_mounted_o),
		.filesize_o     (filesize)
	);

	// File size in LBA mode, otherwise the current buffer byte
	assign ctl_rdata_o = ctl_lba_sel_i ? disk_geometry_pkg::ctl_word_t'(filesize)
	                                   : disk_geometry_pkg::ctl_word_t'(bus.rdata);

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic areset
);

	// 40 ns period
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Reset held for four cycles, released on a falling edge
	initial begin
		areset = 1'b1;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		areset = 1'b0;
	end

endmodule

// File: verif/disk_bridge_tb.sv
// Disk sector bridge testbench
`timescale 1ns/1ps

module disk_bridge_tb;

	typedef enum logic [2:0] {
		WRITE_LBA,
		FILL,
		READBACK,
		HOST_CHECK,
		BLOCK,
		MOUNT
	} op_kind_t;

	// Mount fields and expected values are only used by MOUNT rows
	typedef struct packed {
		op_kind_t    op;
		int          count;
		logic [7:0]  mask;
		logic        ro;
		logic [1:0]  ftype;
		logic [31:0] size;
		logic [2:0]  exp_fileno;
		logic        exp_ro;
	} entry_t;

	localparam int NUM_ENTRIES = 18;

	// ============================================================
	// Operation table
	// ============================================================
	entry_t op_table [NUM_ENTRIES] = '{
		'{FILL,       64, 8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{READBACK,   64, 8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{WRITE_LBA,  0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{HOST_CHECK, 32, 8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{FILL,       16, 8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{READBACK,   40, 8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{WRITE_LBA,  0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{BLOCK,      0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{BLOCK,      0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{BLOCK,      0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{BLOCK,      0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{BLOCK,      0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{BLOCK,      0,  8'h00,       1'b0, 2'd0, 32'h0000_0000, 3'd0, 1'b0},
		'{MOUNT,      0,  8'b0000_0101, 1'b0, 2'd1, 32'h0001_2000, 3'd2, 1'b0},
		'{MOUNT,      0,  8'b0011_0000, 1'b0, 2'd2, 32'h0000_5A00, 3'd5, 1'b1},
		'{MOUNT,      0,  8'b1000_0010, 1'b1, 2'd3, 32'h00FF_0000, 3'd7, 1'b1},
		'{MOUNT,      0,  8'b0001_0001, 1'b0, 2'd0, 32'h0000_0200, 3'd4, 1'b1},
		'{MOUNT,      0,  8'b0000_1000, 1'b0, 2'd2, 32'h0016_8000, 3'd3, 1'b0}
	};

	logic        clk_sys;
	logic        areset;
	logic        ctl_lba_sel_i;
	logic        ctl_data_wr_i;
	logic        ctl_data_rd_i;
	logic        ctl_io_wr_i;
	logic        ctl_block_rd_i;
	logic        ctl_block_wr_i;
	logic [2:0]  ctl_drive_i;
	logic [31:0] ctl_wdata_i;
	logic [31:0] ctl_rdata_o;
	logic        ctl_io_done_o;
	logic        ctl_mounted_o;
	logic [2:0]  ctl_fileno_o;
	logic [1:0]  ctl_filetype_o;
	logic        ctl_readonly_o;
	logic [31:0] host_lba_o;
	logic [7:0]  host_rd_req_o;
	logic [7:0]  host_wr_req_o;
	logic [7:0]  host_buf_rdata_o;
	logic [7:0]  host_ack_i;
	logic [8:0]  host_buf_addr_i;
	logic [7:0]  host_buf_wdata_i;
	logic        host_buf_we_i;
	logic [7:0]  img_mounted_i;
	logic        img_readonly_i;
	logic [31:0] img_size_i;
	logic [1:0]  img_type_i;

	logic [15:0] lfsr_state = 16'd54392;
	logic [7:0]  shadow [512];
	logic [8:0]  addr_model;
	logic        mounted_exp;
	int          error_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	tb_clock_gen u_clk (
		.clk_sys (clk_sys),
		.areset  (areset)
	);

	disk_bridge_top UUT (.*);

	// Run limit, checked every cycle
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the table did not complete", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	// ============================================================
	// Random bits and reporting
	// ============================================================
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end else begin
			return s >> 1;
		end
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		error_count++;
		$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("Check failed at %0t: %s", $time, msg);
	endtask

	// Worst case per row, used for the run limit
	function automatic int entry_cycles(input entry_t e);
		case (e.op)
			FILL:       return 4 * e.count + 4;
			READBACK:   return 3 * e.count + 4;
			HOST_CHECK: return 6 * e.count + 8;
			WRITE_LBA:  return 8;
			BLOCK:      return 24;
			default:    return 6;
		endcase
	endfunction

	// ============================================================
	// Controller buffer operations
	// ============================================================
	task automatic pulse_io_wr;
		ctl_io_wr_i = 1'b1;
		@(negedge clk_sys);
		ctl_io_wr_i = 1'b0;
		addr_model = 9'd0;
		@(negedge clk_sys);
	endtask

	// Strobe stays high two cycles and low two so each edge is seen once
	task automatic strobe_write(input logic [31:0] word, input logic sel);
		ctl_lba_sel_i = sel;
		ctl_wdata_i   = word;
		ctl_data_wr_i = 1'b1;
		repeat (2) @(negedge clk_sys);
		ctl_data_wr_i = 1'b0;
		repeat (2) @(negedge clk_sys);
		ctl_lba_sel_i = 1'b0;
	endtask

	task automatic fill_bytes(input int n);
		logic [31:0] bits;
		pulse_io_wr();
		for (int i = 0; i < n; i++) begin
			take_bits(8, bits);
			// Upper bytes must not reach the buffer
			strobe_write({24'hA5A5A5, bits[7:0]}, 1'b0);
			shadow[addr_model] = bits[7:0];
			addr_model = addr_model + 9'd1;
		end
	endtask

	task automatic read_back(input int n);
		pulse_io_wr();
		for (int i = 0; i < n; i++) begin
			if (ctl_rdata_o !== {24'h0, shadow[addr_model]}) begin
				report_value("ctl_rdata_o", ctl_rdata_o, {24'h0, shadow[addr_model]});
			end
			if (i != n - 1) begin
				ctl_data_rd_i = 1'b1;
				@(negedge clk_sys);
				ctl_data_rd_i = 1'b0;
				repeat (2) @(negedge clk_sys);
				addr_model = addr_model + 9'd1;
			end
		end
	endtask

	task automatic load_lba;
		logic [31:0] word;
		take_bits(32, word);
		strobe_write(word, 1'b1);
		if (host_lba_o !== word) begin
			report_value("host_lba_o", host_lba_o, word);
		end
		// Address must not have moved
		@(negedge clk_sys);
		if (ctl_rdata_o !== {24'h0, shadow[addr_model]}) begin
			report_value("ctl_rdata_o", ctl_rdata_o, {24'h0, shadow[addr_model]});
		end
	endtask

	task automatic host_port_check(input int n);
		logic [31:0] bits;
		for (int a = 0; a < n; a++) begin
			host_buf_addr_i = 9'(a);
			@(negedge clk_sys);
			if (host_buf_rdata_o !== shadow[9'(a)]) begin
				report_value("host_buf_rdata_o", 32'(host_buf_rdata_o), 32'(shadow[9'(a)]));
			end
		end
		for (int a = 0; a < n; a++) begin
			take_bits(8, bits);
			host_buf_addr_i  = 9'(a);
			host_buf_wdata_i = bits[7:0];
			host_buf_we_i    = 1'b1;
			@(negedge clk_sys);
			shadow[9'(a)] = bits[7:0];
		end
		host_buf_we_i = 1'b0;
		read_back(n);
	endtask

	// ============================================================
	// Block requests and mount events
	// ============================================================
	task automatic check_requests(input logic [7:0] exp_rd, input logic [7:0] exp_wr,
		input logic exp_done);
		if (host_rd_req_o !== exp_rd) begin
			report_value("host_rd_req_o", 32'(host_rd_req_o), 32'(exp_rd));
		end
		if (host_wr_req_o !== exp_wr) begin
			report_value("host_wr_req_o", 32'(host_wr_req_o), 32'(exp_wr));
		end
		if (ctl_io_done_o !== exp_done) begin
			report_value("ctl_io_done_o", 32'(ctl_io_done_o), 32'(exp_done));
		end
	endtask

	// Host model answers after a random delay and holds ack a random time
	task automatic run_block;
		logic [31:0] bits;
		logic        is_write;
		logic [2:0]  drv;
		logic [7:0]  exp_rd;
		logic [7:0]  exp_wr;
		int          dly;
		int          hold;
		int          wait_cnt;
		take_bits(1, bits);
		is_write = bits[0];
		take_bits(3, bits);
		drv = bits[2:0];
		take_bits(2, bits);
		dly = int'(bits[1:0]) + 4;
		take_bits(2, bits);
		hold = int'(bits[1:0]) + 1;
		exp_rd = is_write ? 8'h00 : (8'h01 << drv);
		exp_wr = is_write ? (8'h01 << drv) : 8'h00;

		ctl_drive_i    = drv;
		ctl_block_rd_i = !is_write;
		ctl_block_wr_i = is_write;
		@(negedge clk_sys);
		check_requests(exp_rd, exp_wr, 1'b0);

		// Second start edge on another slot while busy
		for (int k = 0; k < dly; k++) begin
			ctl_block_rd_i = (k == 1) && !is_write;
			ctl_block_wr_i = (k == 1) && is_write;
			if (k == 1)
				ctl_drive_i = drv ^ 3'd1;
			@(negedge clk_sys);
			check_requests(exp_rd, exp_wr, 1'b0);
		end

		host_ack_i = host_rd_req_o | host_wr_req_o;
		@(negedge clk_sys);
		check_requests(8'h00, 8'h00, 1'b0);
		repeat (hold) begin
			@(negedge clk_sys);
			check_requests(8'h00, 8'h00, 1'b0);
		end
		host_ack_i = 8'h00;

		wait_cnt = 0;
		while (!ctl_io_done_o && wait_cnt < 4) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (!ctl_io_done_o) begin
			report_failure($sformatf("io_done stayed low after ack release, drive %0d", drv));
		end
		check_requests(8'h00, 8'h00, 1'b1);
	endtask

	task automatic run_mount(input entry_t e);
		img_mounted_i  = e.mask;
		img_readonly_i = e.ro;
		img_type_i     = e.ftype;
		img_size_i     = e.size;
		mounted_exp    = !mounted_exp;
		@(negedge clk_sys);
		if (ctl_fileno_o !== e.exp_fileno) begin
			report_value("ctl_fileno_o", 32'(ctl_fileno_o), 32'(e.exp_fileno));
		end
		if (ctl_filetype_o !== e.ftype) begin
			report_value("ctl_filetype_o", 32'(ctl_filetype_o), 32'(e.ftype));
		end
		if (ctl_readonly_o !== e.exp_ro) begin
			report_value("ctl_readonly_o", 32'(ctl_readonly_o), 32'(e.exp_ro));
		end
		if (ctl_mounted_o !== mounted_exp) begin
			report_value("ctl_mounted_o", 32'(ctl_mounted_o), 32'(mounted_exp));
		end
		// Size read back must be the captured one, not the live input
		img_mounted_i = 8'h00;
		img_size_i    = 32'h0;
		ctl_lba_sel_i = 1'b1;
		@(negedge clk_sys);
		if (ctl_rdata_o !== e.size) begin
			report_value("ctl_rdata_o", ctl_rdata_o, e.size);
		end
		ctl_lba_sel_i = 1'b0;
		@(negedge clk_sys);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		ctl_lba_sel_i    = 1'b0;
		ctl_data_wr_i    = 1'b0;
		ctl_data_rd_i    = 1'b0;
		ctl_io_wr_i      = 1'b0;
		ctl_block_rd_i   = 1'b0;
		ctl_block_wr_i   = 1'b0;
		ctl_drive_i      = 3'd0;
		ctl_wdata_i      = 32'h0;
		host_ack_i       = 8'h00;
		host_buf_addr_i  = 9'd0;
		host_buf_wdata_i = 8'h00;
		host_buf_we_i    = 1'b0;
		img_mounted_i    = 8'h00;
		img_readonly_i   = 1'b0;
		img_size_i       = 32'h0;
		img_type_i       = 2'd0;
		addr_model       = 9'd0;
		mounted_exp      = 1'b0;

		// Reset cycles plus margin
		cycle_limit = 108;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			cycle_limit += entry_cycles(op_table[i]);
		end

		wait (areset == 1'b0);
		@(negedge clk_sys);
		check_requests(8'h00, 8'h00, 1'b1);
		if (ctl_mounted_o !== 1'b0) begin
			report_value("ctl_mounted_o", 32'(ctl_mounted_o), 32'h0);
		end
		if (host_lba_o !== 32'h0) begin
			report_value("host_lba_o", host_lba_o, 32'h0);
		end

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			case (op_table[i].op)
				FILL:       fill_bytes(op_table[i].count);
				READBACK:   read_back(op_table[i].count);
				WRITE_LBA:  load_lba();
				HOST_CHECK: host_port_check(op_table[i].count);
				BLOCK:      run_block();
				default:    run_mount(op_table[i]);
			endcase
		end

		$display("Entries run: %0d, errors: %0d", NUM_ENTRIES, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
rtl/disk_geometry_pkg.sv
rtl/bridge_ctrl_pkg.sv
rtl/sector_bus_if.sv
rtl/sector_buffer.sv
rtl/buffer_addr_counter.sv
rtl/block_request_fsm.sv
rtl/mount_tracker.sv
rtl/disk_bridge_top.sv
verif/tb_clock_gen.sv
verif/disk_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the disk bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module disk_bridge_tb -o disk_bridge_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/disk_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0
